// ==== project.f ====
src/dispatch_pkg.sv
src/lane_step_if.sv
src/brick_lane.sv
src/dispatch_ctrl.sv
src/brick_dispatcher.sv
testbench/dispatch_scoreboard.sv
testbench/tb_brick_dispatcher.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/100ps -f project.f \
		--top-module tb_brick_dispatcher -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| exit 1

// ==== testbench/tb_brick_dispatcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_brick_dispatcher
	import dispatch_pkg::*;
();

	localparam int N_PHASES     = 4;
	localparam int PHASE_BRICKS = 40;
	localparam int WATCH_CYCLES = 200;
	localparam int HOLD_PERIOD  = 600;
	localparam int HOLD_LEN     = 80;

	logic               clk;
	logic               rst_n;
	logic               zfnaf;
	logic [N_LANES-1:0] brick_valid;
	brick_values_t      brick_values [N_LANES];
	brick_offsets_t     brick_offsets [N_LANES];
	logic [N_LANES-1:0] brick_credit;
	logic               out_valid;
	value_t             out_value [N_LANES];
	offset_t            out_offset [N_LANES];
	logic               out_credit;

	integer seed;
	bit     phase_zf;
	int     cycle;
	int     bricks_sent;
	int     beats;
	int     outstanding;

	// supplier state per lane
	int             credit_cnt [N_LANES];
	int             sent_cnt [N_LANES];
	int             wait_cnt [N_LANES];
	bit             armed [N_LANES];
	brick_values_t  plan_vals [N_LANES][$];
	brick_offsets_t plan_offs [N_LANES][$];

	// cycle at which each beat's credit goes back
	int return_q [$];

	brick_dispatcher uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.zfnaf         (zfnaf),
		.brick_valid   (brick_valid),
		.brick_values  (brick_values),
		.brick_offsets (brick_offsets),
		.brick_credit  (brick_credit),
		.out_valid     (out_valid),
		.out_value     (out_value),
		.out_offset    (out_offset),
		.out_credit    (out_credit)
	);

	dispatch_scoreboard sb ();

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// lead below zero gives a free brick, otherwise exactly lead leading nonzero values
	task automatic make_brick(int lead, output brick_values_t vals, output brick_offsets_t offs);
		value_t e;
		for (int i = 0; i < BRICK_DEPTH; i++) begin
			e = value_t'($random(seed));
			if (rand_below(6) == 0) begin
				e = '0;
			end
			if (i < lead && e == '0) begin
				e = value_t'(1);
			end else if (i == lead) begin
				e = '0;
			end
			vals[i*VALUE_W +: VALUE_W] = e;
			offs[i*OFFSET_W +: OFFSET_W] = offset_t'($random(seed));
		end
	endtask

	task automatic plan_phase();
		int             totals [N_LANES];
		int             top;
		int             k;
		brick_values_t  vals;
		brick_offsets_t offs;
		top = 0;
		for (int g = 0; g < N_LANES; g++) begin
			totals[g] = 0;
			for (int b = 0; b < PHASE_BRICKS; b++) begin
				make_brick(-1, vals, offs);
				plan_vals[g].push_back(vals);
				plan_offs[g].push_back(offs);
				totals[g] += sb.stream_length(phase_zf, vals);
			end
			if (totals[g] > top) begin
				top = totals[g];
			end
		end
		// lanes must run dry on the same beat, else lockstep stalls at the phase end
		for (int g = 0; g < N_LANES; g++) begin
			while (totals[g] < top) begin
				k = (top - totals[g] > BRICK_DEPTH) ? BRICK_DEPTH : top - totals[g];
				make_brick(k, vals, offs);
				plan_vals[g].push_back(vals);
				plan_offs[g].push_back(offs);
				totals[g] += k;
			end
		end
	endtask

	task automatic count_credits();
		for (int g = 0; g < N_LANES; g++) begin
			if (brick_credit[g]) begin
				credit_cnt[g]++;
				if (credit_cnt[g] > sent_cnt[g] + 1) begin
					abort_run($sformatf("lane %0d got a brick credit it had not earned", g));
				end
			end
		end
	endtask

	task automatic check_beat();
		value_t  want_value;
		offset_t want_offset;
		int      due;
		bit      ok;
		if (out_valid) begin
			for (int g = 0; g < N_LANES; g++) begin
				if (sent_cnt[g] == 0) begin
					abort_run($sformatf("beat issued before lane %0d loaded a brick", g));
				end
				sb.pop_entry(g, want_value, want_offset, ok);
				if (!ok) begin
					abort_run($sformatf("beat on lane %0d with no entry left to send", g));
				end
				sb.check_value($sformatf("out_value[%0d]", g), out_value[g], want_value, ok);
				if (!ok) begin
					abort_run("beat carried a wrong value");
				end
				sb.check_offset($sformatf("out_offset[%0d]", g), out_offset[g], want_offset, ok);
				if (!ok) begin
					abort_run("beat carried a wrong offset");
				end
			end
			beats++;
			outstanding++;
			if (outstanding > OUT_CREDITS) begin
				abort_run("more beats in flight than output credits");
			end
			due = cycle + rand_below(7);
			if (return_q.size() != 0 && due <= return_q[$]) begin
				due = return_q[$] + 1;
			end
			return_q.push_back(due);
		end
	endtask

	// neuron lane side withholds credits for a periodic stretch
	task automatic return_credits();
		bit hold;
		bit pulse;
		hold = (cycle % HOLD_PERIOD) >= HOLD_PERIOD - HOLD_LEN;
		pulse = 1'b0;
		if (!hold && return_q.size() != 0 && return_q[0] <= cycle) begin
			void'(return_q.pop_front());
			outstanding--;
			pulse = 1'b1;
		end
		out_credit <= pulse;
	endtask

	task automatic feed_lanes();
		logic [N_LANES-1:0] valid_next;
		valid_next = '0;
		for (int g = 0; g < N_LANES; g++) begin
			if (!armed[g] && credit_cnt[g] > sent_cnt[g] && plan_vals[g].size() != 0) begin
				armed[g] = 1'b1;
				wait_cnt[g] = rand_below(6);
			end
			if (armed[g] && wait_cnt[g] != 0) begin
				wait_cnt[g]--;
			end else if (armed[g]) begin
				brick_values[g]  <= plan_vals[g][0];
				brick_offsets[g] <= plan_offs[g][0];
				sb.push_brick(g, phase_zf, plan_vals[g][0], plan_offs[g][0]);
				void'(plan_vals[g].pop_front());
				void'(plan_offs[g].pop_front());
				sent_cnt[g]++;
				bricks_sent++;
				armed[g] = 1'b0;
				valid_next[g] = 1'b1;
			end
		end
		brick_valid <= valid_next;
	endtask

	function automatic bit lanes_idle();
		bit idle;
		idle = 1'b1;
		for (int g = 0; g < N_LANES; g++) begin
			if (armed[g] || plan_vals[g].size() != 0 || sb.pending(g) != 0) begin
				idle = 1'b0;
			end
			if (credit_cnt[g] != sent_cnt[g] + 1) begin
				idle = 1'b0;
			end
		end
		return idle;
	endfunction

	task automatic step_cycle();
		cycle++;
		count_credits();
		check_beat();
		return_credits();
		feed_lanes();
	endtask

	initial begin : run_test
		seed = 32'h83a5;
		phase_zf = 1'b0;
		rst_n = 1'b0;
		zfnaf = 1'b0;
		brick_valid = '0;
		out_credit = 1'b0;
		for (int g = 0; g < N_LANES; g++) begin
			brick_values[g] = '0;
			brick_offsets[g] = '0;
			credit_cnt[g] = 0;
			sent_cnt[g] = 0;
			wait_cnt[g] = 0;
			armed[g] = 1'b0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// dense first as for a first layer, then alternate
		for (int ph = 0; ph < N_PHASES; ph++) begin
			phase_zf = (ph % 2) == 1;
			zfnaf <= phase_zf;
			plan_phase();
			do begin
				@(posedge clk);
				step_cycle();
			end while (!lanes_idle());
		end
		while (return_q.size() != 0) begin
			@(posedge clk);
			step_cycle();
		end
		$display("%0d bricks sent, %0d beats checked", bricks_sent, beats);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// budget grows with every brick handed over
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > WATCH_CYCLES * (bricks_sent + 1)) begin
				abort_run($sformatf("watchdog expired after %0d cycles", cycles));
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/dispatch_scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_scoreboard
	import dispatch_pkg::*;
();

	// expected entry stream of each lane with the oldest entry first
	value_t  want_value  [N_LANES][$];
	offset_t want_offset [N_LANES][$];

	// a zfnaf brick ends at its first zero value, a dense one goes out whole
	function automatic int stream_length(bit zf, brick_values_t vals);
		int n;
		n = BRICK_DEPTH;
		if (zf) begin
			for (int i = BRICK_DEPTH - 1; i >= 0; i--) begin
				if (vals[i*VALUE_W +: VALUE_W] == '0) begin
					n = i;
				end
			end
		end
		return n;
	endfunction

	task automatic push_brick(
		input  int             lane,
		input  bit             zf,
		input  brick_values_t  vals,
		input  brick_offsets_t offs
	);
		int n;
		n = stream_length(zf, vals);
		for (int i = 0; i < n; i++) begin
			want_value[lane].push_back(vals[i*VALUE_W +: VALUE_W]);
			want_offset[lane].push_back(offs[i*OFFSET_W +: OFFSET_W]);
		end
	endtask

	function automatic int pending(int lane);
		return want_value[lane].size();
	endfunction

	task automatic pop_entry(int lane, output value_t value, output offset_t offset, output bit ok);
		ok = want_value[lane].size() != 0;
		value = '0;
		offset = '0;
		if (ok) begin
			value  = want_value[lane].pop_front();
			offset = want_offset[lane].pop_front();
		end
	endtask

	task automatic check_value(string name, value_t got, value_t want, output bit ok);
		ok = (got === want);
		if (!ok) begin
			$display("ERROR: %s is 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_offset(string name, offset_t got, offset_t want, output bit ok);
		ok = (got === want);
		if (!ok) begin
			$display("ERROR: %s is 0x%h, expected 0x%h", name, got, want);
		end
	endtask

endmodule

`default_nettype wire

// ==== src/brick_dispatcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module brick_dispatcher
	import dispatch_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               zfnaf,

	// brick supplier side
	input  logic [N_LANES-1:0] brick_valid,
	input  brick_values_t      brick_values [N_LANES],
	input  brick_offsets_t     brick_offsets [N_LANES],
	output logic [N_LANES-1:0] brick_credit,

	// neuron lane side
	output logic               out_valid,
	output value_t             out_value [N_LANES],
	output offset_t            out_offset [N_LANES],
	input  logic               out_credit
);

	lane_step_if lane_if [N_LANES] ();

	dispatch_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.lanes      (lane_if),
		.out_credit (out_credit),
		.out_valid  (out_valid)
	);

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		brick_lane u_lane (
			.clk           (clk),
			.rst_n         (rst_n),
			.zfnaf         (zfnaf),
			.ctrl          (lane_if[g]),
			.brick_valid   (brick_valid[g]),
			.brick_values  (brick_values[g]),
			.brick_offsets (brick_offsets[g]),
			.brick_credit  (brick_credit[g]),
			.out_value     (out_value[g]),
			.out_offset    (out_offset[g])
		);
	end

endmodule

`default_nettype wire

// ==== src/dispatch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_ctrl
	import dispatch_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	lane_step_if.ctrl lanes [N_LANES],
	input  logic      out_credit,
	output logic      out_valid
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// credits left toward the neuron lanes
	credit_t credits;

	logic [N_LANES-1:0] entry_vec;
	logic               all_ready;
	logic               step;
	logic               run;

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		assign entry_vec[g]  = lanes[g].has_entry;
		assign lanes[g].step = step;
		assign lanes[g].run  = run;
	end

	// one cycle in CTRL_RESET lets every lane issue its first credit
	always_comb begin
		state_next = state;
		case (state)
			CTRL_RESET: state_next = CTRL_RUN;
			CTRL_RUN:   state_next = CTRL_RUN;
			default:    state_next = CTRL_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CTRL_RESET;
		end else begin
			state <= state_next;
		end
	end

	assign run = (state == CTRL_RESET);

	// a single empty lane holds back the lockstep beat
	assign all_ready = &entry_vec;
	assign step      = all_ready && (credits != '0);

	// returned credit and a beat in the same cycle cancel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= credit_t'(OUT_CREDITS);
		end else begin
			case ({out_credit, step})
				2'b10:   credits <= credits + credit_t'(1);
				2'b01:   credits <= credits - credit_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	// lanes register their heads on step, so valid lines up one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= step;
		end
	end

	// neuron lanes never hand back more than was spent
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= credit_t'(OUT_CREDITS));

	a_credit_return: assert property (@(posedge clk) disable iff (!rst_n)
		out_credit && !step |-> credits < credit_t'(OUT_CREDITS));

	// no beat appears without a step in the cycle before
	a_valid_step: assert property (@(posedge clk) disable iff (!rst_n)
		!step |=> !out_valid);

endmodule

`default_nettype wire

// ==== src/brick_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module brick_lane
	import dispatch_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           zfnaf,
	lane_step_if.lane      ctrl,
	input  logic           brick_valid,
	input  brick_values_t  brick_values,
	input  brick_offsets_t brick_offsets,
	output logic           brick_credit,
	output value_t         out_value,
	output offset_t        out_offset
);

	// brick buffer with the head entry in the low bits
	brick_values_t  vals;
	brick_offsets_t offs;

	count_t count;
	count_t lead;
	count_t load_count;

	logic empty_load;
	logic last_step;
	logic credit_next;

	// set while the supplier owns a credit and no brick came back yet
	logic credit_held;

	// leading nonzero run of the incoming brick
	always_comb begin
		logic stop;
		stop = 1'b0;
		lead = '0;
		for (int i = 0; i < BRICK_DEPTH; i++) begin
			if (brick_values[i*VALUE_W +: VALUE_W] == '0) begin
				stop = 1'b1;
			end
			if (!stop) begin
				lead = lead + count_t'(1);
			end
		end
	end

	// zfnaf is only looked at when the brick lands
	assign load_count = zfnaf ? lead : count_t'(BRICK_DEPTH);

	// a brick with nothing to send hands the credit straight back
	assign empty_load  = brick_valid && (load_count == '0);
	assign last_step   = ctrl.step && ctrl.last_entry;
	assign credit_next = ctrl.run || empty_load || last_step;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count        <= '0;
			brick_credit <= 1'b0;
		end else begin
			brick_credit <= credit_next;
			if (brick_valid) begin
				count <= load_count;
			end else if (ctrl.step) begin
				count <= count - count_t'(1);
			end
		end
	end

	assign ctrl.count = count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit_held <= 1'b0;
		end else if (brick_credit) begin
			credit_held <= 1'b1;
		end else if (brick_valid) begin
			credit_held <= 1'b0;
		end
	end

	// shift one entry out per beat
	always_ff @(posedge clk) begin
		if (brick_valid) begin
			vals <= brick_values;
			offs <= brick_offsets;
		end else if (ctrl.step) begin
			vals <= vals >> VALUE_W;
			offs <= offs >> OFFSET_W;
		end
	end

	// registered head toward the neuron lane
	always_ff @(posedge clk) begin
		if (ctrl.step) begin
			out_value  <= vals[VALUE_W-1:0];
			out_offset <= offs[OFFSET_W-1:0];
		end
	end

	// a brick lands only in an empty lane
	a_load_empty: assert property (@(posedge clk) disable iff (!rst_n)
		brick_valid |-> !ctrl.has_entry);

	// beats from the control module never hit a drained lane
	a_step_entry: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.step |-> ctrl.has_entry);

	// supplier answers a credit, and never gets a second one meanwhile
	a_load_credit: assert property (@(posedge clk) disable iff (!rst_n)
		brick_valid |-> credit_held);

	a_one_credit: assert property (@(posedge clk) disable iff (!rst_n)
		brick_credit |-> !credit_held);

endmodule

`default_nettype wire

// ==== src/lane_step_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface lane_step_if
	import dispatch_pkg::*;
();

	// entry count as seen by the lane
	count_t count;

	// flags decoded from the lane's entry count
	logic has_entry;
	logic last_entry;

	// shared beat and start pulses from the control module
	logic step;
	logic run;

	assign has_entry  = (count != '0);
	assign last_entry = (count == count_t'(1));

	modport lane (
		output count,
		input  has_entry,
		input  last_entry,
		input  step,
		input  run
	);

	modport ctrl (
		input  has_entry,
		output step,
		output run
	);

endinterface

`default_nettype wire

// ==== src/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

	// lane geometry
	localparam int N_LANES     = 4;
	localparam int BRICK_DEPTH = 16;
	localparam int VALUE_W     = 16;
	localparam int OFFSET_W    = 4;

	// beats the neuron lanes can absorb before returning credit
	localparam int OUT_CREDITS = 4;

	// derived widths
	localparam int COUNT_W     = $clog2(BRICK_DEPTH + 1);
	localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);
	localparam int BRICK_W     = BRICK_DEPTH * VALUE_W;
	localparam int BRICK_OFF_W = BRICK_DEPTH * OFFSET_W;

	// one activation and its offset
	typedef logic [VALUE_W-1:0]  value_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// 0 to BRICK_DEPTH entries left in a lane
	typedef logic [COUNT_W-1:0] count_t;

	// 0 to OUT_CREDITS output credits held
	typedef logic [CREDIT_W-1:0] credit_t;

	// whole brick with entry 0 in the low bits
	typedef logic [BRICK_W-1:0]     brick_values_t;
	typedef logic [BRICK_OFF_W-1:0] brick_offsets_t;

	typedef enum logic {
		CTRL_RESET,
		CTRL_RUN
	} ctrl_state_t;

endpackage

`default_nettype wire
